// File: design/loader_pkg.sv
/* serial loader shared definitions */

package loader_pkg;

    localparam int byte_w       = 8;    // data byte
    localparam int addr_frame_w = 24;   // three address bytes in a frame

    // command byte values
    typedef enum logic [7:0] {
        cmd_write = 8'h57,
        cmd_read  = 8'h52
    } cmd_e;

    // command engine states
    typedef enum logic [3:0] {
        st_cmd,
        st_addr_hi,
        st_addr_mid,
        st_addr_lo,
        st_len,
        st_write,
        st_read_req,
        st_read_wait,
        st_send
    } engine_state_e;

endpackage

// File: design/uart_rx.sv
/* uart receiver, 8N1 */
`timescale 1ns/1ns

module uart_rx import loader_pkg::*; #(
    parameter int clks_per_bit = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rx,
    output logic [byte_w-1:0] rx_data,
    output logic              rx_stb,
    output logic              frame_err
);
    localparam int cnt_w = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] bit_last  = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);

    typedef enum logic [2:0] {rx_idle, rx_start, rx_bits, rx_stop, rx_done} rx_state_e;

    rx_state_e         state;
    logic              rx_meta;
    logic              rx_sync;
    logic [cnt_w-1:0]  cnt;
    logic [2:0]        bit_idx;
    logic              stop_ok;
    logic [byte_w-1:0] shift;

    assign rx_data = shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta   <= 1'b1;
            rx_sync   <= 1'b1;
            state     <= rx_idle;
            cnt       <= '0;
            bit_idx   <= '0;
            stop_ok   <= 1'b0;
            rx_stb    <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rx_meta   <= rx;            // two-flop sync
            rx_sync   <= rx_meta;
            rx_stb    <= 1'b0;
            frame_err <= 1'b0;
            cnt       <= cnt + 1'b1;
            case (state)
                rx_idle: begin
                    cnt <= '0;
                    if (!rx_sync) state <= rx_start;    // falling edge of start bit
                end
                rx_start: if (cnt == half_last) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    state   <= rx_sync ? rx_idle : rx_bits;  // glitch rejected
                end
                rx_bits: if (cnt == bit_last) begin
                    cnt     <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= rx_stop;
                end
                rx_stop: if (cnt == bit_last) begin
                    cnt     <= '0;
                    stop_ok <= rx_sync;
                    state   <= rx_done;
                end
                rx_done: if (cnt == half_last) begin
                    rx_stb    <= stop_ok;
                    frame_err <= !stop_ok;
                    state     <= rx_idle;
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state == rx_bits && cnt == bit_last) shift <= {rx_sync, shift[byte_w-1:1]};
    end

endmodule

// File: design/uart_tx.sv
/* uart transmitter, 8N1 */
`timescale 1ns/1ns

module uart_tx import loader_pkg::*; #(
    parameter int clks_per_bit = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [byte_w-1:0] tx_data,
    input  logic              tx_start,
    output logic              tx,
    output logic              tx_busy
);
    localparam int cnt_w = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] bit_last = cnt_w'(clks_per_bit - 1);

    logic [cnt_w-1:0] cnt;
    logic [3:0]       bit_cnt;      // bits already on the line
    logic [byte_w:0]  shift;        // data bits, then stop bit

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx      <= 1'b0;    // start bit
                tx_busy <= 1'b1;
                cnt     <= '0;
                bit_cnt <= '0;
            end
        end else if (cnt == bit_last) begin
            cnt <= '0;
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;    // stop bit done, line stays high
            end else begin
                tx      <= shift[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            shift <= {1'b1, tx_data};
        end else if (tx_busy && cnt == bit_last) begin
            shift <= {1'b1, shift[byte_w:1]};
        end
    end

endmodule

// File: design/serial_cmd_engine.sv
/* serial command frame engine */
`timescale 1ns/1ns

module serial_cmd_engine import loader_pkg::*; #(
    parameter int addr_w = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [byte_w-1:0] rx_data,
    input  logic              rx_stb,
    input  logic              tx_busy,
    input  logic [byte_w-1:0] mem_rdata,
    output logic [byte_w-1:0] tx_data,
    output logic              tx_start,
    output logic              eng_req,
    output logic              eng_we,
    output logic [addr_w-1:0] eng_addr,
    output logic [byte_w-1:0] eng_wdata
);
    localparam logic [byte_w:0] full_len = 1 << byte_w;    // length byte 0

    engine_state_e           state;
    cmd_e                    cmd;
    logic [addr_frame_w-1:0] addr;
    logic [byte_w:0]         count;     // 1..256 bytes left
    logic                    rd_valid;  // mem_rdata holds our read

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_cmd;
            eng_req  <= 1'b0;
            tx_start <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            eng_req  <= 1'b0;
            tx_start <= 1'b0;
            rd_valid <= eng_req & ~eng_we;
            case (state)
                st_cmd:      if (rx_stb) state <= st_addr_hi;
                st_addr_hi:  if (rx_stb) state <= st_addr_mid;
                st_addr_mid: if (rx_stb) state <= st_addr_lo;
                st_addr_lo:  if (rx_stb) state <= st_len;
                st_len: if (rx_stb) begin
                    case (cmd)
                        cmd_write: state <= st_write;
                        cmd_read:  state <= st_read_req;
                        default:   state <= st_cmd;     // unknown, drop frame
                    endcase
                end
                st_write: if (rx_stb) begin
                    eng_req <= 1'b1;
                    if (count == 1) state <= st_cmd;
                end
                st_read_req: begin
                    eng_req <= 1'b1;
                    state   <= st_read_wait;
                end
                st_read_wait: if (rd_valid) state <= st_send;
                st_send: if (!tx_busy) begin
                    tx_start <= 1'b1;
                    state    <= (count == 1) ? st_cmd : st_read_req;
                end
                default: state <= st_cmd;
            endcase
        end
    end

    // frame fields and memory request payload
    always_ff @(posedge clk) begin
        case (state)
            st_cmd: if (rx_stb) cmd <= cmd_e'(rx_data);
            st_addr_hi, st_addr_mid, st_addr_lo: begin
                if (rx_stb) addr <= {addr[addr_frame_w-byte_w-1:0], rx_data};   // high first
            end
            st_len: if (rx_stb) count <= (rx_data == '0) ? full_len : {1'b0, rx_data};
            st_write: if (rx_stb) begin
                eng_we    <= 1'b1;
                eng_addr  <= addr[addr_w-1:0];
                eng_wdata <= rx_data;
                addr      <= addr + 1'b1;
                count     <= count - 1'b1;
            end
            st_read_req: begin
                eng_we   <= 1'b0;
                eng_addr <= addr[addr_w-1:0];
            end
            st_read_wait: if (rd_valid) tx_data <= mem_rdata;  // hold while tx is busy
            st_send: if (!tx_busy) begin
                addr  <= addr + 1'b1;
                count <= count - 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: design/mem_arbiter.sv
/* memory arbiter, engine first */
`timescale 1ns/1ns

module mem_arbiter import loader_pkg::*; #(
    parameter int addr_w = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              eng_req,
    input  logic              eng_we,
    input  logic [addr_w-1:0] eng_addr,
    input  logic [byte_w-1:0] eng_wdata,
    input  logic              host_req,
    input  logic              host_we,
    input  logic [addr_w-1:0] host_addr,
    input  logic [byte_w-1:0] host_wdata,
    input  logic [byte_w-1:0] ram_rdata,
    output logic [byte_w-1:0] mem_rdata,
    output logic [byte_w-1:0] host_rdata,
    output logic              host_rvalid,
    output logic              ram_en,
    output logic              ram_we,
    output logic [addr_w-1:0] ram_addr,
    output logic [byte_w-1:0] ram_wdata
);
    logic              pend_valid;
    logic              pend_we;
    logic [addr_w-1:0] pend_addr;
    logic [byte_w-1:0] pend_wdata;
    logic              host_go;     // host access reaches the ram this cycle
    logic              rd_host;     // last ram read was for the host

    assign host_go   = !eng_req && (pend_valid || host_req);
    assign ram_en    = eng_req || host_go;
    assign ram_we    = eng_req ? eng_we    : (pend_valid ? pend_we    : host_we);
    assign ram_addr  = eng_req ? eng_addr  : (pend_valid ? pend_addr  : host_addr);
    assign ram_wdata = eng_req ? eng_wdata : (pend_valid ? pend_wdata : host_wdata);

    assign host_rvalid = rd_host;
    assign host_rdata  = rd_host ? ram_rdata : '0;
    assign mem_rdata   = rd_host ? '0 : ram_rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
            rd_host    <= 1'b0;
        end else begin
            if (host_req && eng_req) pend_valid <= 1'b1;    // collision, park it
            else if (!eng_req)       pend_valid <= 1'b0;
            rd_host <= host_go && !ram_we;
        end
    end

    always_ff @(posedge clk) begin
        if (host_req && eng_req) begin
            pend_we    <= host_we;
            pend_addr  <= host_addr;
            pend_wdata <= host_wdata;
        end
    end

endmodule

// File: design/byte_ram.sv
/* single-port byte memory */
`timescale 1ns/1ns

module byte_ram import loader_pkg::*; #(
    parameter int addr_w = 10
) (
    input  logic              clk,
    input  logic              ram_en,
    input  logic              ram_we,
    input  logic [addr_w-1:0] ram_addr,
    input  logic [byte_w-1:0] ram_wdata,
    output logic [byte_w-1:0] ram_rdata
);
    logic [byte_w-1:0] mem [2**addr_w];

    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[ram_addr] <= ram_wdata;
            end
            ram_rdata <= mem[ram_addr];     // old data on a write
        end
    end

endmodule

// File: design/loader_top.sv
/* serial memory loader top */
`timescale 1ns/1ns

module loader_top import loader_pkg::*; #(
    parameter int addr_w       = 10,
    parameter int clks_per_bit = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rx,
    input  logic              host_req,
    input  logic              host_we,
    input  logic [addr_w-1:0] host_addr,
    input  logic [byte_w-1:0] host_wdata,
    output logic              tx,
    output logic [byte_w-1:0] host_rdata,
    output logic              host_rvalid,
    output logic              frame_err
);
    logic [byte_w-1:0] rx_data;
    logic              rx_stb;
    logic [byte_w-1:0] tx_data;
    logic              tx_start;
    logic              tx_busy;
    logic              eng_req;
    logic              eng_we;
    logic [addr_w-1:0] eng_addr;
    logic [byte_w-1:0] eng_wdata;
    logic [byte_w-1:0] mem_rdata;
    logic              ram_en;
    logic              ram_we;
    logic [addr_w-1:0] ram_addr;
    logic [byte_w-1:0] ram_wdata;
    logic [byte_w-1:0] ram_rdata;

    uart_rx #(.clks_per_bit(clks_per_bit)) uart_rx_inst (.*);

    uart_tx #(.clks_per_bit(clks_per_bit)) uart_tx_inst (.*);

    serial_cmd_engine #(.addr_w(addr_w)) serial_cmd_engine_inst (.*);

    mem_arbiter #(.addr_w(addr_w)) mem_arbiter_inst (.*);

    byte_ram #(.addr_w(addr_w)) byte_ram_inst (.*);

endmodule

// File: verif/tb_clock_gen.sv
/* testbench clock and reset */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #10 rst_n = 1'b1;   // released off the edge like other inputs
    end

endmodule

// File: verif/tb_loader.sv
/* serial loader testbench */
`timescale 1ns/1ns

module tb_loader import loader_pkg::*; ();
    localparam int addr_w       = 10;
    localparam int clks_per_bit = 8;
    localparam int drive_dly    = 10;
    localparam int serial_bytes = 91 + 304;    // rx bytes plus tx bytes of all tests
    localparam int cycle_limit  = serial_bytes * 10 * clks_per_bit + 5000;

    logic              clk;
    logic              rst_n;
    logic              rx;
    logic              host_req;
    logic              host_we;
    logic [addr_w-1:0] host_addr;
    logic [byte_w-1:0] host_wdata;
    logic              tx;
    logic [byte_w-1:0] host_rdata;
    logic              host_rvalid;
    logic              frame_err;

    logic [byte_w-1:0] ref_mem [2**addr_w];
    logic [byte_w-1:0] tx_q [$];                // bytes decoded from tx
    integer            seed = 32'hcf79;
    int                mismatches = 0;
    int                failures   = 0;
    int                cycles     = 0;
    int                frame_errs = 0;
    logic              burst_done;

    tb_clock_gen clock_gen_inst (.clk(clk), .rst_n(rst_n));

    loader_top #(.addr_w(addr_w), .clks_per_bit(clks_per_bit)) loader_top_inst (.*);

    function automatic logic [byte_w-1:0] expect_read(input logic [addr_w-1:0] addr);
        return ref_mem[addr];
    endfunction

    task automatic check_byte(input logic [byte_w-1:0] got, input logic [addr_w-1:0] addr,
                              input string what);
        assert (got == expect_read(addr)) else begin
            mismatches++;
            $display("MISMATCH at %0t ns: %s addr %h got %h expected %h",
                     $time, what, addr, got, expect_read(addr));
        end
    endtask

    task automatic send_byte(input logic [byte_w-1:0] data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #drive_dly rx = frame[i];
            repeat (clks_per_bit - 1) @(posedge clk);
        end
        @(posedge clk);
        #drive_dly rx = 1'b1;
        repeat (2) @(posedge clk);  // idle gap so the receiver rearms
    endtask

    task automatic send_header(input logic [byte_w-1:0] cmd,
                               input logic [addr_frame_w-1:0] addr,
                               input logic [byte_w-1:0] len);
        logic [39:0] hdr;
        hdr = {cmd, addr, len};
        for (int i = 4; i >= 0; i--) send_byte(hdr[i*8 +: 8], 1'b1);   // command first
    endtask

    task automatic serial_write(input logic [addr_frame_w-1:0] addr, input int len);
        logic [byte_w-1:0] data;
        send_header(cmd_write, addr, byte_w'(len));
        for (int i = 0; i < len; i++) begin
            data = byte_w'($random(seed));
            ref_mem[addr_w'(addr + i)] = data;  // wraps with the memory
            send_byte(data, 1'b1);
        end
    endtask

    task automatic serial_read(input logic [addr_frame_w-1:0] addr, input int len);
        tx_q.delete();
        send_header(cmd_read, addr, byte_w'(len));
        while (tx_q.size() < len) @(negedge clk);
        repeat (20 * clks_per_bit) @(negedge clk);  // room for stray extra bytes
        assert (tx_q.size() == len) else begin
            failures++;
            $display("serial read at %h returned %0d bytes, not %0d", addr, tx_q.size(), len);
        end
        for (int i = 0; i < len; i++) check_byte(tx_q[i], addr_w'(addr + i), "serial read");
    endtask

    // one host strobe with rvalid 1 or 2 cycles later on reads only
    task automatic host_access(input logic we, input logic [addr_w-1:0] addr,
                               input logic [byte_w-1:0] wdata);
        logic got;
        @(posedge clk);
        #drive_dly;
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        if (we) ref_mem[addr] = wdata;
        @(posedge clk);
        #drive_dly host_req = 1'b0;
        got = 1'b0;
        for (int i = 0; i < 2 && !got; i++) begin
            @(negedge clk);
            if (host_rvalid) begin
                got = 1'b1;
                if (!we) check_byte(host_rdata, addr, "host read");
            end
        end
        assert (got == !we) else begin
            failures++;
            $display("host %s at %h: rvalid %0s", we ? "write" : "read", addr,
                     we ? "pulsed on a write" : "never came");
        end
    endtask

    // tx decoder samples mid-bit on the falling edge
    initial begin
        logic [byte_w-1:0] data;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (tx == 1'b0) begin
                repeat (clks_per_bit / 2) @(negedge clk);
                for (int i = 0; i < byte_w; i++) begin
                    repeat (clks_per_bit) @(negedge clk);
                    data[i] = tx;
                end
                repeat (clks_per_bit) @(negedge clk);
                assert (tx == 1'b1) else begin
                    failures++;
                    $display("tx stop bit low at %0t ns", $time);
                end
                tx_q.push_back(data);
            end
        end
    end

    always @(negedge clk) begin
        if (frame_err) frame_errs++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        logic [addr_frame_w-1:0] base;
        rx         = 1'b1;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        burst_done = 1'b0;
        wait (rst_n === 1'b1);
        repeat (4) @(posedge clk);

        // serial burst wrapping past the top of memory and read back by the host
        base = addr_frame_w'($random(seed));
        base[addr_w-1:0] = 10'h3f8;
        serial_write(base, 16);
        for (int i = 0; i < 16; i++) host_access(1'b0, addr_w'(base + i), '0);

        // host writes, serial reads, then a length byte of zero
        for (int i = 0; i < 8; i++) begin
            host_access(1'b1, addr_w'(10'h040 + i), byte_w'($random(seed)));
        end
        serial_read(24'h000040, 8);
        for (int i = 0; i < 256; i++) begin
            host_access(1'b1, addr_w'(10'h100 + i), byte_w'($random(seed)));
        end
        serial_read(24'h5a0100, 256);

        // host traffic colliding with a serial write burst
        fork
            begin
                serial_write(24'h000080, 16);
                burst_done = 1'b1;
            end
            for (int i = 0; !burst_done; i++) begin
                host_access(1'b1, addr_w'(10'h090 + i % 16), byte_w'($random(seed)));
                repeat ($unsigned($random(seed)) % 3) @(posedge clk);
                host_access(1'b0, addr_w'(10'h090 + i % 16), '0);
                host_access(1'b0, addr_w'(i % 8), '0);     // wrapped part of the first burst
            end
        join
        serial_read(24'h000080, 32);

        // unknown command dropped after its header
        tx_q.delete();
        send_header(8'h41, 24'h0000c0, 8'h04);
        serial_write(24'h0000c0, 4);
        repeat (20 * clks_per_bit) @(negedge clk);
        assert (tx_q.size() == 0) else begin
            failures++;
            $display("unknown command produced %0d tx bytes", tx_q.size());
        end
        serial_read(24'h0000c0, 4);

        // low stop bit, then a normal frame
        send_byte(cmd_write, 1'b0);
        repeat (3 * clks_per_bit) @(negedge clk);
        assert (frame_errs == 1) else begin
            failures++;
            $display("frame_err pulsed %0d times, expected once", frame_errs);
        end
        serial_write(24'h0000d0, 4);
        serial_read(24'h0000d0, 4);

        $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: list.f
design/loader_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/serial_cmd_engine.sv
design/mem_arbiter.sv
design/byte_ram.sv
design/loader_top.sv
verif/tb_clock_gen.sv
verif/tb_loader.sv

// File: run.sh
#!/bin/sh
# build and run the loader testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_loader -f list.f -o sim_loader
out=$(./obj_dir/sim_loader)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
    exit 0
else
    exit 1
fi
